/* rtl/trigger_macros.svh */
// ----------------------------
// trigger controller constants
// ----------------------------
`ifndef TRIGGER_MACROS_SVH
`define TRIGGER_MACROS_SVH

`define TRIGGER_WIDTH       8
`define WORD_WIDTH          32
`define BUS_ADDR_WIDTH      16
`define FIFO_DEPTH          8
`define VERSION             8'd11

// register map, one byte each
`define ADDR_VERSION        16'd0
`define ADDR_CONF           16'd1
`define ADDR_THRESHOLD      16'd2
`define ADDR_TRIGGER_SELECT 16'd3
`define ADDR_VETO_SELECT    16'd4
`define ADDR_TRIGGER_INVERT 16'd5
`define ADDR_SOFT_TRIGGER   16'd6
`define ADDR_COUNTER        16'd8  // 8..11, little-endian
`define ADDR_COUNTER_MAX    16'd12 // 12..15
`define ADDR_LOST           16'd16

`define REG_RESET           8'h00
`define COUNTER_MAX_RESET   32'h0

`endif

/* rtl/trigger_pkg.sv */
// ----------------------------
// trigger types
// ----------------------------
package trigger_pkg;

    typedef enum logic [1:0] {
        FMT_COUNTER   = 2'd0,
        FMT_TIMESTAMP = 2'd1,
        FMT_COMBINED  = 2'd2 // code 3 is handled as counter
    } data_format_e;

    typedef struct packed {
        logic        marker; // always 1
        logic [30:0] number;
    } counter_word_t;

    typedef struct packed {
        logic        marker;
        logic [30:0] stamp;
    } timestamp_word_t;

    // short stamp in the upper half, short number in the lower
    typedef struct packed {
        logic        marker;
        logic [14:0] stamp;
        logic [15:0] number;
    } combined_word_t;

    typedef union packed {
        counter_word_t   cnt_view;
        timestamp_word_t ts_view;
        combined_word_t  comb_view;
    } trigger_word_t;

endpackage

/* rtl/trigger_conf_if.sv */
// ----------------------------
// configuration interface
// ----------------------------
`timescale 1ns/1ps
`include "trigger_macros.svh"

interface trigger_conf_if;
    import trigger_pkg::*;

    logic [`TRIGGER_WIDTH-1:0] trigger_select;
    logic [`TRIGGER_WIDTH-1:0] veto_select;
    logic [`TRIGGER_WIDTH-1:0] trigger_invert;
    logic [7:0]                threshold;      // hold cycles before accept
    data_format_e              data_format;
    logic                      trigger_enable;
    logic [`WORD_WIDTH-1:0]    counter_max;    // 0 means no limit

    modport regs (
        output trigger_select, veto_select, trigger_invert, threshold,
        output data_format, trigger_enable, counter_max
    );
    modport inputs (input trigger_select, veto_select, trigger_invert);
    modport timer (input threshold, counter_max);
    modport fsm (input trigger_enable, data_format);

endinterface

/* rtl/trigger_reg_bank.sv */
// ----------------------------
// register bank
// ----------------------------
`timescale 1ns/1ps
`include "trigger_macros.svh"

module trigger_reg_bank (
    input  logic                       BUS_CLK,
    input  logic                       RST_SYNC,
    input  logic [`BUS_ADDR_WIDTH-1:0] bus_add,
    input  logic [7:0]                 bus_data_in,
    input  logic                       bus_rd,
    input  logic                       bus_wr,
    input  logic [`WORD_WIDTH-1:0]     trigger_count,
    input  logic [7:0]                 lost_count,
    output logic [7:0]                 bus_data_out,
    output logic                       soft_rst,
    output logic                       soft_trigger,
    trigger_conf_if.regs               conf
);
    import trigger_pkg::*;

    logic [23:0] count_snap; // counter bytes 1..3, taken on byte 0 read
    logic [7:0]  read_mux;

    // both strobes act at the write edge
    assign soft_rst     = bus_wr && (bus_add == `ADDR_VERSION);
    assign soft_trigger = bus_wr && (bus_add == `ADDR_SOFT_TRIGGER);

    always_ff @(posedge BUS_CLK)
    begin
        if (RST_SYNC || soft_rst)
        begin
            conf.trigger_enable <= 1'b0;
            conf.data_format    <= FMT_COUNTER;
            conf.threshold      <= `REG_RESET;
            conf.trigger_select <= `REG_RESET;
            conf.veto_select    <= `REG_RESET;
            conf.trigger_invert <= `REG_RESET;
            conf.counter_max    <= `COUNTER_MAX_RESET;
        end
        else if (bus_wr)
        begin
            case (bus_add)
                `ADDR_CONF:
                begin
                    conf.trigger_enable <= bus_data_in[0];
                    conf.data_format    <= data_format_e'(bus_data_in[2:1]);
                end
                `ADDR_THRESHOLD:             conf.threshold <= bus_data_in;
                `ADDR_TRIGGER_SELECT:        conf.trigger_select <= bus_data_in;
                `ADDR_VETO_SELECT:           conf.veto_select <= bus_data_in;
                `ADDR_TRIGGER_INVERT:        conf.trigger_invert <= bus_data_in;
                `ADDR_COUNTER_MAX:           conf.counter_max[7:0] <= bus_data_in;
                `ADDR_COUNTER_MAX + 16'd1:   conf.counter_max[15:8] <= bus_data_in;
                `ADDR_COUNTER_MAX + 16'd2:   conf.counter_max[23:16] <= bus_data_in;
                `ADDR_COUNTER_MAX + 16'd3:   conf.counter_max[31:24] <= bus_data_in;
                default: ;
            endcase
        end
    end

    always_comb
    begin
        case (bus_add)
            `ADDR_VERSION:              read_mux = `VERSION;
            `ADDR_CONF:
                read_mux = {5'b0, conf.data_format, conf.trigger_enable};
            `ADDR_THRESHOLD:            read_mux = conf.threshold;
            `ADDR_TRIGGER_SELECT:       read_mux = conf.trigger_select;
            `ADDR_VETO_SELECT:          read_mux = conf.veto_select;
            `ADDR_TRIGGER_INVERT:       read_mux = conf.trigger_invert;
            `ADDR_COUNTER:              read_mux = trigger_count[7:0];
            `ADDR_COUNTER + 16'd1:      read_mux = count_snap[7:0]; // from snapshot
            `ADDR_COUNTER + 16'd2:      read_mux = count_snap[15:8];
            `ADDR_COUNTER + 16'd3:      read_mux = count_snap[23:16];
            `ADDR_COUNTER_MAX:          read_mux = conf.counter_max[7:0];
            `ADDR_COUNTER_MAX + 16'd1:  read_mux = conf.counter_max[15:8];
            `ADDR_COUNTER_MAX + 16'd2:  read_mux = conf.counter_max[23:16];
            `ADDR_COUNTER_MAX + 16'd3:  read_mux = conf.counter_max[31:24];
            `ADDR_LOST:                 read_mux = lost_count;
            default:                    read_mux = 8'h00; // soft trigger reads 0
        endcase
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (bus_rd)
            bus_data_out <= read_mux;
        if (bus_rd && (bus_add == `ADDR_COUNTER))
            count_snap <= trigger_count[31:8];
    end

endmodule

/* rtl/trigger_input.sv */
// ----------------------------
// trigger and veto inputs
// ----------------------------
`timescale 1ns/1ps
`include "trigger_macros.svh"

module trigger_input (
    input  logic                      BUS_CLK,
    input  logic                      RST_SYNC,
    input  logic [`TRIGGER_WIDTH-1:0] trigger,
    input  logic [`TRIGGER_WIDTH-1:0] trigger_veto,
    input  logic                      soft_trigger,
    trigger_conf_if.inputs            conf,
    output logic                      trigger_level,
    output logic                      veto_level
);
    localparam int W = `TRIGGER_WIDTH;

    logic [2*W-1:0] sync_q1; // veto in the upper half
    logic [2*W-1:0] sync_q2;
    logic [W-1:0]   trig_sel;
    logic [W-1:0]   veto_sel;

    always_ff @(posedge BUS_CLK)
    begin
        sync_q1 <= {trigger_veto, trigger};
        sync_q2 <= sync_q1;
    end

    assign trig_sel = (sync_q2[W-1:0] ^ conf.trigger_invert) & conf.trigger_select;
    assign veto_sel = sync_q2[2*W-1:W] & conf.veto_select;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST_SYNC)
        begin
            trigger_level <= 1'b0;
            veto_level    <= 1'b0;
        end
        else
        begin
            trigger_level <= (|trig_sel) || soft_trigger; // soft trigger skips sync
            veto_level    <= |veto_sel;
        end
    end

endmodule

/* rtl/trigger_timer.sv */
// ----------------------------
// timestamp and counters
// ----------------------------
`timescale 1ns/1ps
`include "trigger_macros.svh"

module trigger_timer (
    input  logic                   BUS_CLK,
    input  logic                   RST_SYNC,
    input  logic                   soft_rst,
    input  logic                   trigger_level,
    input  logic                   accept,
    trigger_conf_if.timer          conf,
    output logic [`WORD_WIDTH-1:0] timestamp,
    output logic [`WORD_WIDTH-1:0] trigger_count,
    output logic                   held_long_enough,
    output logic                   limit_reached
);
    logic       clear;
    logic [7:0] hold_cnt; // cycles the level was high before this one

    assign clear = RST_SYNC || soft_rst;

    always_ff @(posedge BUS_CLK)
    begin
        if (clear)
        begin
            timestamp     <= '0;
            hold_cnt      <= '0;
            trigger_count <= '0;
            limit_reached <= 1'b0;
        end
        else
        begin
            timestamp <= timestamp + 1'b1; // free running
            if (!trigger_level)
                hold_cnt <= '0;
            else if (hold_cnt != 8'hff)
                hold_cnt <= hold_cnt + 1'b1;
            if (accept)
                trigger_count <= trigger_count + 1'b1;
            limit_reached <= (conf.counter_max != '0) && (trigger_count >= conf.counter_max);
        end
    end

    // threshold 0 passes in the first high cycle
    assign held_long_enough = trigger_level && (hold_cnt >= conf.threshold);

endmodule

/* rtl/trigger_fsm.sv */
// ----------------------------
// trigger accept FSM
// ----------------------------
`timescale 1ns/1ps
`include "trigger_macros.svh"

module trigger_fsm (
    input  logic                   BUS_CLK,
    input  logic                   RST_SYNC,
    input  logic                   soft_rst,
    input  logic                   trigger_level,
    input  logic                   veto_level,
    input  logic                   held_long_enough,
    input  logic                   limit_reached,
    input  logic [`WORD_WIDTH-1:0] trigger_count,
    input  logic [`WORD_WIDTH-1:0] timestamp,
    trigger_conf_if.fsm            conf,
    output logic                   accept,
    output logic                   word_write,
    output trigger_pkg::trigger_word_t word_data,
    output logic                   trigger_enabled
);
    import trigger_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCEPT,
        WAIT_LOW
    } state_t;

    state_t state;
    logic   start;

    assign start = trigger_enabled && !limit_reached && !veto_level && held_long_enough;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST_SYNC || soft_rst)
        begin
            state           <= IDLE;
            trigger_enabled <= 1'b0;
        end
        else
        begin
            trigger_enabled <= conf.trigger_enable && !limit_reached;
            case (state)
                IDLE:     if (start) state <= ACCEPT;
                ACCEPT:   state <= WAIT_LOW;
                WAIT_LOW: if (!trigger_level) state <= IDLE; // one trigger per pulse
                default:  state <= IDLE;
            endcase
        end
    end

    assign accept     = (state == ACCEPT);
    assign word_write = (state == ACCEPT);

    // count still holds the value before this accept
    always_comb
    begin
        case (conf.data_format)
            FMT_TIMESTAMP:
            begin
                word_data.ts_view.marker = 1'b1;
                word_data.ts_view.stamp  = timestamp[30:0];
            end
            FMT_COMBINED:
            begin
                word_data.comb_view.marker = 1'b1;
                word_data.comb_view.stamp  = timestamp[14:0];
                word_data.comb_view.number = trigger_count[15:0];
            end
            default:
            begin
                word_data.cnt_view.marker = 1'b1;
                word_data.cnt_view.number = trigger_count[30:0];
            end
        endcase
    end

endmodule

/* rtl/trigger_fifo.sv */
// ----------------------------
// trigger word FIFO
// ----------------------------
`timescale 1ns/1ps
`include "trigger_macros.svh"

module trigger_fifo (
    input  logic                   BUS_CLK,
    input  logic                   RST_SYNC,
    input  logic                   soft_rst,
    input  logic                   word_write,
    input  logic [`WORD_WIDTH-1:0] word_data,
    input  logic                   fifo_read,
    output logic                   fifo_empty,
    output logic [`WORD_WIDTH-1:0] fifo_data,
    output logic [7:0]             lost_count
);
    localparam int PTR_WIDTH = $clog2(`FIFO_DEPTH);

    logic [`WORD_WIDTH-1:0] mem [`FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [PTR_WIDTH:0]     fill;
    logic                   full;
    logic                   do_write;
    logic                   do_read;

    assign full       = (fill == (PTR_WIDTH+1)'(`FIFO_DEPTH));
    assign fifo_empty = (fill == '0);
    assign fifo_data  = mem[rd_ptr]; // head, first word falls through
    assign do_write   = word_write && !full;
    assign do_read    = fifo_read && !fifo_empty;

    always_ff @(posedge BUS_CLK)
    begin
        if (do_write)
            mem[wr_ptr] <= word_data;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST_SYNC || soft_rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            lost_count <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_write && !do_read)
                fill <= fill + 1'b1;
            else if (do_read && !do_write)
                fill <= fill - 1'b1;
            if (word_write && full && lost_count != 8'hff)
                lost_count <= lost_count + 1'b1; // saturates
        end
    end

endmodule

/* rtl/trigger_controller.sv */
// ----------------------------
// trigger controller top
// ----------------------------
`timescale 1ns/1ps
`include "trigger_macros.svh"

module trigger_controller (
    input  logic                       BUS_CLK,
    input  logic                       RST_SYNC,
    input  logic [`BUS_ADDR_WIDTH-1:0] bus_add,
    input  logic [7:0]                 bus_data_in,
    input  logic                       bus_rd,
    input  logic                       bus_wr,
    output logic [7:0]                 bus_data_out,
    input  logic [`TRIGGER_WIDTH-1:0]  trigger,
    input  logic [`TRIGGER_WIDTH-1:0]  trigger_veto,
    input  logic                       fifo_read,
    output logic                       fifo_empty,
    output logic [`WORD_WIDTH-1:0]     fifo_data,
    output logic                       trigger_enabled,
    output logic                       trigger_accepted
);
    import trigger_pkg::*;

    logic                   soft_rst;
    logic                   soft_trigger;
    logic                   trigger_level;
    logic                   veto_level;
    logic                   held_long_enough;
    logic                   limit_reached;
    logic [`WORD_WIDTH-1:0] trigger_count;
    logic [`WORD_WIDTH-1:0] timestamp;
    logic                   word_write;
    trigger_word_t          word_data;
    logic [7:0]             lost_count;

    trigger_conf_if conf ();

    trigger_reg_bank u_reg_bank (
        .BUS_CLK       (BUS_CLK),
        .RST_SYNC      (RST_SYNC),
        .bus_add       (bus_add),
        .bus_data_in   (bus_data_in),
        .bus_rd        (bus_rd),
        .bus_wr        (bus_wr),
        .trigger_count (trigger_count),
        .lost_count    (lost_count),
        .bus_data_out  (bus_data_out),
        .soft_rst      (soft_rst),
        .soft_trigger  (soft_trigger),
        .conf          (conf.regs)
    );

    trigger_input u_input (
        .BUS_CLK       (BUS_CLK),
        .RST_SYNC      (RST_SYNC),
        .trigger       (trigger),
        .trigger_veto  (trigger_veto),
        .soft_trigger  (soft_trigger),
        .conf          (conf.inputs),
        .trigger_level (trigger_level),
        .veto_level    (veto_level)
    );

    trigger_timer u_timer (
        .BUS_CLK          (BUS_CLK),
        .RST_SYNC         (RST_SYNC),
        .soft_rst         (soft_rst),
        .trigger_level    (trigger_level),
        .accept           (trigger_accepted),
        .conf             (conf.timer),
        .timestamp        (timestamp),
        .trigger_count    (trigger_count),
        .held_long_enough (held_long_enough),
        .limit_reached    (limit_reached)
    );

    trigger_fsm u_fsm (
        .BUS_CLK          (BUS_CLK),
        .RST_SYNC         (RST_SYNC),
        .soft_rst         (soft_rst),
        .trigger_level    (trigger_level),
        .veto_level       (veto_level),
        .held_long_enough (held_long_enough),
        .limit_reached    (limit_reached),
        .trigger_count    (trigger_count),
        .timestamp        (timestamp),
        .conf             (conf.fsm),
        .accept           (trigger_accepted),
        .word_write       (word_write),
        .word_data        (word_data),
        .trigger_enabled  (trigger_enabled)
    );

    // word goes in as raw bits
    trigger_fifo u_fifo (
        .BUS_CLK    (BUS_CLK),
        .RST_SYNC   (RST_SYNC),
        .soft_rst   (soft_rst),
        .word_write (word_write),
        .word_data  (word_data),
        .fifo_read  (fifo_read),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .lost_count (lost_count)
    );

endmodule

/* sim/tb_trigger_controller.sv */
// ----------------------------
// trigger controller testbench
// ----------------------------
`timescale 1ns/1ps
`include "trigger_macros.svh"

module tb_trigger_controller;

    localparam int WAIT_LIMIT = 200; // cycles before a FIFO wait gives up
    localparam int PULSE_GAP  = 8;   // low cycles after each pin pulse

    logic                       BUS_CLK;
    logic                       RST_SYNC;
    logic [`BUS_ADDR_WIDTH-1:0] bus_add;
    logic [7:0]                 bus_data_in;
    logic                       bus_rd;
    logic                       bus_wr;
    logic [7:0]                 bus_data_out;
    logic [`TRIGGER_WIDTH-1:0]  trigger;
    logic [`TRIGGER_WIDTH-1:0]  trigger_veto;
    logic                       fifo_read;
    logic                       fifo_empty;
    logic [`WORD_WIDTH-1:0]     fifo_data;
    logic                       trigger_enabled;
    logic                       trigger_accepted;
    logic [`WORD_WIDTH-1:0]     last_word; // previous popped word, for stamp order
    int                         accept_total; // cycles with accept high since time zero
    int                         accept_base;  // total at the last soft reset

    trigger_controller DUT (
        .BUS_CLK          (BUS_CLK),
        .RST_SYNC         (RST_SYNC),
        .bus_add          (bus_add),
        .bus_data_in      (bus_data_in),
        .bus_rd           (bus_rd),
        .bus_wr           (bus_wr),
        .bus_data_out     (bus_data_out),
        .trigger          (trigger),
        .trigger_veto     (trigger_veto),
        .fifo_read        (fifo_read),
        .fifo_empty       (fifo_empty),
        .fifo_data        (fifo_data),
        .trigger_enabled  (trigger_enabled),
        .trigger_accepted (trigger_accepted)
    );

    initial
    begin
        BUS_CLK = 1'b0;
        forever #50 BUS_CLK = ~BUS_CLK;
    end

    // accept pulses, sampled on the falling edge
    always @(negedge BUS_CLK)
    begin
        if (trigger_accepted === 1'b1)
            accept_total++;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
        if (exp_val !== act_val)
        begin
            $display("Fail %s: expected %h, actual %h", name, exp_val, act_val);
            abort_run();
        end
    endtask

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge BUS_CLK);
        #1;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] value);
        bus_add     = addr;
        bus_data_in = value;
        bus_wr      = 1'b1;
        next_cycle();
        bus_wr      = 1'b0;
        if (addr == `ADDR_VERSION)
            accept_base = accept_total; // trigger counter restarts at zero
    endtask

    task automatic bus_read_check(input string name, input logic [15:0] addr,
                                  input logic [7:0] exp_val);
        bus_add = addr;
        bus_rd  = 1'b1;
        next_cycle();
        bus_rd  = 1'b0;
        check(name, {24'b0, exp_val}, {24'b0, bus_data_out}); // registered read data
        if (addr == `ADDR_COUNTER)
            check({name, " accept pulses"}, {24'b0, exp_val}, accept_total - accept_base);
    endtask

    task automatic pulse_pins(input logic [7:0] pins, input int high_cycles, input int pulses);
        for (int p = 0; p < pulses; p++)
        begin
            trigger = pins;
            repeat (high_cycles) next_cycle();
            trigger = '0;
            repeat (PULSE_GAP) next_cycle();
        end
    endtask

    task automatic pop_word(input string name, input logic stamp_check,
                            input logic [31:0] mask, input logic [31:0] exp_val);
        int waited;
        waited = 0;
        while (fifo_empty && waited < WAIT_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (fifo_empty)
        begin
            $display("timeout: no word reached the FIFO for %s", name);
            abort_run();
        end
        check(name, exp_val & mask, fifo_data & mask);
        if (stamp_check)
            check({name, " stamp order"}, 32'd1, {31'b0, fifo_data[30:0] > last_word[30:0]});
        last_word = fifo_data;
        fifo_read = 1'b1;
        next_cycle();
        fifo_read = 1'b0;
    endtask

    task automatic expect_empty(input string name, input int cycles);
        for (int c = 0; c < cycles; c++)
        begin
            check(name, 32'd1, {31'b0, fifo_empty});
            next_cycle();
        end
    endtask

    initial
    begin
        int          fd;
        int          lineno;
        int          n;
        string       line;
        string       name;
        logic [7:0]  op;
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] exp_val;

        RST_SYNC     = 1'b1;
        bus_add      = '0;
        bus_data_in  = '0;
        bus_rd       = 1'b0;
        bus_wr       = 1'b0;
        trigger      = '0;
        trigger_veto = '0;
        fifo_read    = 1'b0;
        last_word    = '0;
        accept_base  = 0;
        repeat (8) @(posedge BUS_CLK);
        #1;
        RST_SYNC = 1'b0;

        fd = $fopen("sim/trigger_stim.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file sim/trigger_stim.txt");
            abort_run();
        end
        lineno = 0;
        while ($fgets(line, fd) != 0)
        begin
            lineno++;
            if (line.len() < 2 || line[0] == "#")
                continue; // blank or comment
            n = $sscanf(line, "%c %h %h %h", op, arg, data, exp_val);
            if (n != 4)
            begin
                $display("stimulus line %0d is malformed", lineno);
                abort_run();
            end
            name = $sformatf("line %0d op %c", lineno, op);
            case (op)
                "W": bus_write(arg[15:0], data[7:0]);
                "R": bus_read_check(name, arg[15:0], exp_val[7:0]);
                "P": pulse_pins(arg[7:0], data, exp_val);
                "V": trigger_veto = arg[7:0];
                "F": pop_word(name, arg[0], data, exp_val);
                "E": expect_empty(name, data);
                "N": check(name, exp_val, {31'b0, trigger_enabled});
                default:
                begin
                    $display("unknown opcode %c on stimulus line %0d", op, lineno);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* sim/trigger_stim.txt */
# op arg data expect, all hex; W addr value, R addr - expect, P pins cycles pulses, V veto pins
# F stampcheck mask expect, E - cycles -, N - - trigger_enabled
# registers after reset and readback
N 0 0 0
R 0 0 0b
R 2 0 00
W 3 a5 0
W 4 3c 0
W 5 81 0
R 3 0 a5
R 4 0 3c
R 5 0 81
W 4 00 0
W 5 00 0
# counter format, three pulses on input 0
W 3 01 0
W 1 01 0
P 01 4 3
N 0 0 1
F 0 ffffffff 80000000
F 0 ffffffff 80000001
F 0 ffffffff 80000002
R 8 0 03
R 9 0 00
R a 0 00
R b 0 00
# unselected input, then vetoed input
P 02 4 1
E 0 a 0
W 4 01 0
V 01 0 0
P 01 4 1
E 0 a 0
V 00 0 0
# inverted input 1 fires while its pin is low
W 5 02 0
W 3 02 0
F 0 ffffffff 80000003
P 02 a 1
F 0 ffffffff 80000004
W 3 01 0
W 5 00 0
# soft trigger
W 6 00 0
F 0 ffffffff 80000005
# threshold 5
W 2 05 0
P 01 5 1
E 0 a 0
P 01 6 1
F 0 ffffffff 80000006
E 0 a 0
W 2 00 0
R 8 0 07
# counter max 2 after soft reset
W 0 00 0
R 1 0 00
W 3 01 0
W c 02 0
W 1 01 0
P 01 4 3
F 0 ffffffff 80000000
F 0 ffffffff 80000001
E 0 a 0
N 0 0 0
R 8 0 02
R c 0 02
# overflow in timestamp format
W 0 00 0
W 3 01 0
W 1 03 0
P 01 3 a
R 10 0 02
R 8 0 0a
F 0 80000000 80000000
F 1 80000000 80000000
W 0 00 0
E 0 a 0

/* verilog.f */
+incdir+rtl
rtl/trigger_pkg.sv
rtl/trigger_conf_if.sv
rtl/trigger_reg_bank.sv
rtl/trigger_input.sv
rtl/trigger_timer.sv
rtl/trigger_fsm.sv
rtl/trigger_fifo.sv
rtl/trigger_controller.sv
sim/tb_trigger_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the trigger controller testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot change to the project directory"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module tb_trigger_controller -Mdir obj_dir -o sim_trigger
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_trigger 2>&1)
status=$?
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
    if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
    fi
    exit 0
fi
exit 1
